//--- logic/soc_consts.svh
// ------------------------------------------------
// Address map is 32-bit; regions must not overlap
// and base plus length must not wrap past 2^32
// ------------------------------------------------
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// DRAM region, goes out on the AXI-lite port
`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_DRAM_LEN  32'h2000_0000

// APB region, reached through the bridge
`define SOC_APB_BASE 32'h6000_0000
`define SOC_APB_LEN  32'h1000_0000

// Answer for accesses outside both regions
`define SOC_RESP_DECERR 2'b11

`endif

//--- logic/soc_pkg.sv
// ------------------------------------------------
// Widths follow soc_consts.svh
// ------------------------------------------------
`include "soc_consts.svh"

package soc_pkg;

   typedef logic [`SOC_ADDR_W-1:0]   addr_t;
   typedef logic [`SOC_DATA_W-1:0]   data_t;
   typedef logic [`SOC_DATA_W/8-1:0] strb_t;
   typedef logic [1:0]               resp_t;

   // Decode result
   typedef enum logic [1:0] {
      TGT_DRAM,
      TGT_APB,
      TGT_NONE
   } target_t;

   // One per direction in the demux
   typedef enum logic [1:0] {
      CH_IDLE,
      CH_BUSY,
      CH_RESP
   } chan_state_t;

   typedef enum logic [1:0] {
      APB_IDLE,
      APB_SETUP,
      APB_ACCESS,
      APB_RESP
   } apb_state_t;

endpackage

//--- logic/axil_if.sv
// ------------------------------------------------
// Single-beat AXI-lite, no prot, no IDs
// ------------------------------------------------
interface axil_if
   import soc_pkg::*;
();

   addr_t aw_addr;
   logic  aw_valid;
   logic  aw_ready;

   data_t w_data;
   strb_t w_strb;
   logic  w_valid;
   logic  w_ready;

   resp_t b_resp;
   logic  b_valid;
   logic  b_ready;

   addr_t ar_addr;
   logic  ar_valid;
   logic  ar_ready;

   data_t r_data;
   resp_t r_resp;
   logic  r_valid;
   logic  r_ready;

   modport mst (
      output aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
      output ar_addr, ar_valid, r_ready,
      input  aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
   );

   modport slv (
      input  aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
      input  ar_addr, ar_valid, r_ready,
      output aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
   );

endinterface

//--- logic/axil_addr_demux.sv
// ------------------------------------------------
// One write and one read in flight; a write is
// taken only when AW and W are valid together
// ------------------------------------------------
`include "soc_consts.svh"

module axil_addr_demux
   import soc_pkg::*;
(
   input logic clk_i,
   input logic arst_n_i,
   axil_if.slv host,
   axil_if.mst dram,
   axil_if.mst apb
);

   chan_state_t wr_state;
   chan_state_t rd_state;
   target_t     wr_tgt;
   target_t     rd_tgt;
   target_t     aw_dec;
   target_t     ar_dec;
   logic        aw_pend;
   logic        w_pend;
   logic        ar_pend;
   logic        wr_accept;
   logic        rd_accept;
   logic        b_take;
   logic        r_take;
   addr_t       aw_addr_q;
   data_t       w_data_q;
   strb_t       w_strb_q;
   addr_t       ar_addr_q;
   resp_t       b_resp_q;
   resp_t       r_resp_q;
   data_t       r_data_q;

   function automatic target_t decode(addr_t addr);
      target_t tgt;
      tgt = TGT_NONE;
      if (addr >= `SOC_DRAM_BASE && (addr - `SOC_DRAM_BASE) < `SOC_DRAM_LEN)
         tgt = TGT_DRAM;
      else if (addr >= `SOC_APB_BASE && (addr - `SOC_APB_BASE) < `SOC_APB_LEN)
         tgt = TGT_APB;
      return tgt;
   endfunction

   assign aw_dec    = decode(host.aw_addr);
   assign ar_dec    = decode(host.ar_addr);
   assign wr_accept = (wr_state == CH_IDLE) && host.aw_valid && host.w_valid;
   assign rd_accept = (rd_state == CH_IDLE) && host.ar_valid;

   // ------------------------------------------------
   // Host side
   // ------------------------------------------------
   assign host.aw_ready = wr_accept;
   assign host.w_ready  = wr_accept;
   assign host.ar_ready = rd_accept;
   assign host.b_valid  = (wr_state == CH_RESP);
   assign host.b_resp   = b_resp_q;
   assign host.r_valid  = (rd_state == CH_RESP);
   assign host.r_resp   = r_resp_q;
   assign host.r_data   = r_data_q;

   // Response is taken once both request beats are out
   assign b_take = (wr_state == CH_BUSY) && !aw_pend && !w_pend &&
                   ((wr_tgt == TGT_DRAM) ? dram.b_valid : apb.b_valid);
   assign r_take = (rd_state == CH_BUSY) && !ar_pend &&
                   ((rd_tgt == TGT_DRAM) ? dram.r_valid : apb.r_valid);

   // ------------------------------------------------
   // Target side steered by the latched target
   // ------------------------------------------------
   assign dram.aw_addr  = aw_addr_q;
   assign dram.w_data   = w_data_q;
   assign dram.w_strb   = w_strb_q;
   assign dram.ar_addr  = ar_addr_q;
   assign dram.aw_valid = (wr_state == CH_BUSY) && aw_pend && (wr_tgt == TGT_DRAM);
   assign dram.w_valid  = (wr_state == CH_BUSY) && w_pend && (wr_tgt == TGT_DRAM);
   assign dram.b_ready  = (wr_state == CH_BUSY) && !aw_pend && !w_pend && (wr_tgt == TGT_DRAM);
   assign dram.ar_valid = (rd_state == CH_BUSY) && ar_pend && (rd_tgt == TGT_DRAM);
   assign dram.r_ready  = (rd_state == CH_BUSY) && !ar_pend && (rd_tgt == TGT_DRAM);

   assign apb.aw_addr  = aw_addr_q;
   assign apb.w_data   = w_data_q;
   assign apb.w_strb   = w_strb_q;
   assign apb.ar_addr  = ar_addr_q;
   assign apb.aw_valid = (wr_state == CH_BUSY) && aw_pend && (wr_tgt == TGT_APB);
   assign apb.w_valid  = (wr_state == CH_BUSY) && w_pend && (wr_tgt == TGT_APB);
   assign apb.b_ready  = (wr_state == CH_BUSY) && !aw_pend && !w_pend && (wr_tgt == TGT_APB);
   assign apb.ar_valid = (rd_state == CH_BUSY) && ar_pend && (rd_tgt == TGT_APB);
   assign apb.r_ready  = (rd_state == CH_BUSY) && !ar_pend && (rd_tgt == TGT_APB);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_state <= CH_IDLE;
         wr_tgt   <= TGT_NONE;
         aw_pend  <= 1'b0;
         w_pend   <= 1'b0;
      end else begin
         case (wr_state)
            CH_IDLE: begin
               if (wr_accept) begin
                  wr_tgt   <= aw_dec;
                  aw_pend  <= (aw_dec != TGT_NONE);
                  w_pend   <= (aw_dec != TGT_NONE);
                  wr_state <= (aw_dec == TGT_NONE) ? CH_RESP : CH_BUSY;
               end
            end
            CH_BUSY: begin
               if ((wr_tgt == TGT_DRAM) ? dram.aw_ready : apb.aw_ready)
                  aw_pend <= 1'b0;
               if ((wr_tgt == TGT_DRAM) ? dram.w_ready : apb.w_ready)
                  w_pend <= 1'b0;
               if (b_take)
                  wr_state <= CH_RESP;
            end
            default: begin
               if (host.b_ready)
                  wr_state <= CH_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_state <= CH_IDLE;
         rd_tgt   <= TGT_NONE;
         ar_pend  <= 1'b0;
      end else begin
         case (rd_state)
            CH_IDLE: begin
               if (rd_accept) begin
                  rd_tgt   <= ar_dec;
                  ar_pend  <= (ar_dec != TGT_NONE);
                  rd_state <= (ar_dec == TGT_NONE) ? CH_RESP : CH_BUSY;
               end
            end
            CH_BUSY: begin
               if ((rd_tgt == TGT_DRAM) ? dram.ar_ready : apb.ar_ready)
                  ar_pend <= 1'b0;
               if (r_take)
                  rd_state <= CH_RESP;
            end
            default: begin
               if (host.r_ready)
                  rd_state <= CH_IDLE;
            end
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge clk_i) begin
      if (wr_accept) begin
         aw_addr_q <= host.aw_addr;
         w_data_q  <= host.w_data;
         w_strb_q  <= host.w_strb;
         b_resp_q  <= `SOC_RESP_DECERR;
      end else if (b_take) begin
         b_resp_q <= (wr_tgt == TGT_DRAM) ? dram.b_resp : apb.b_resp;
      end
      if (rd_accept) begin
         ar_addr_q <= host.ar_addr;
         r_resp_q  <= `SOC_RESP_DECERR;
         r_data_q  <= '0;
      end else if (r_take) begin
         r_resp_q <= (rd_tgt == TGT_DRAM) ? dram.r_resp : apb.r_resp;
         r_data_q <= (rd_tgt == TGT_DRAM) ? dram.r_data : apb.r_data;
      end
   end

   // A write response only follows a decode error or a target response
   a_no_b_when_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(host.b_valid) |->
         ($past(wr_accept && aw_dec == TGT_NONE) && host.b_resp == `SOC_RESP_DECERR) ||
         $past(b_take));

   // Latched target stays the decode of the held address
   a_wr_tgt_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (wr_state != CH_IDLE) |-> (wr_tgt == decode(aw_addr_q)));

   a_rd_tgt_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (rd_state != CH_IDLE) |-> (rd_tgt == decode(ar_addr_q)));

endmodule

//--- logic/axil_apb_bridge.sv
// ------------------------------------------------
// One APB transfer at a time; a pending read goes
// before a pending write
// ------------------------------------------------
module axil_apb_bridge
   import soc_pkg::*;
(
   input  logic  clk_i,
   input  logic  arst_n_i,
   axil_if.slv   axil,
   output addr_t paddr_o,
   output logic  pwrite_o,
   output logic  psel_o,
   output logic  penable_o,
   output data_t pwdata_o,
   output strb_t pstrb_o,
   input  data_t prdata_i,
   input  logic  pready_i,
   input  logic  pslverr_i
);

   localparam resp_t resp_okay   = 2'b00;
   localparam resp_t resp_slverr = 2'b10;

   apb_state_t state;
   logic       rd_accept;
   logic       wr_accept;
   logic       sample;
   logic       pwrite_q;
   addr_t      paddr_q;
   data_t      pwdata_q;
   strb_t      pstrb_q;
   data_t      rdata_q;
   resp_t      resp_q;

   assign rd_accept = (state == APB_IDLE) && axil.ar_valid;
   assign wr_accept = (state == APB_IDLE) && !axil.ar_valid &&
                      axil.aw_valid && axil.w_valid;
   assign sample    = (state == APB_ACCESS) && pready_i;

   assign axil.ar_ready = rd_accept;
   assign axil.aw_ready = wr_accept;
   assign axil.w_ready  = wr_accept;
   assign axil.b_valid  = (state == APB_RESP) && pwrite_q;
   assign axil.r_valid  = (state == APB_RESP) && !pwrite_q;
   assign axil.b_resp   = resp_q;
   assign axil.r_resp   = resp_q;
   assign axil.r_data   = rdata_q;

   // ------------------------------------------------
   // APB pins
   // ------------------------------------------------
   assign psel_o    = (state == APB_SETUP) || (state == APB_ACCESS);
   assign penable_o = (state == APB_ACCESS);
   assign paddr_o   = paddr_q;
   assign pwrite_o  = pwrite_q;
   assign pwdata_o  = pwdata_q;
   assign pstrb_o   = pstrb_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state    <= APB_IDLE;
         pwrite_q <= 1'b0;
      end else begin
         case (state)
            APB_IDLE: begin
               if (rd_accept || wr_accept) begin
                  state    <= APB_SETUP;
                  pwrite_q <= wr_accept;
               end
            end
            APB_SETUP:
               state <= APB_ACCESS;
            APB_ACCESS: begin
               // Wait states hold psel and penable
               if (pready_i)
                  state <= APB_RESP;
            end
            default: begin
               if (pwrite_q ? axil.b_ready : axil.r_ready)
                  state <= APB_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_accept) begin
         paddr_q <= axil.ar_addr;
         pstrb_q <= '0;
      end else if (wr_accept) begin
         paddr_q  <= axil.aw_addr;
         pwdata_q <= axil.w_data;
         pstrb_q  <= axil.w_strb;
      end
      if (sample) begin
         rdata_q <= prdata_i;
         resp_q  <= pslverr_i ? resp_slverr : resp_okay;
      end
   end

   // Setup and wait states lead to access with address and direction held
   a_apb_phase_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (psel_o && !sample) |=>
         psel_o && penable_o && $stable(paddr_o) && $stable(pwrite_o));

endmodule

//--- logic/soc_axil_wrap.sv
// ------------------------------------------------
// DRAM goes out on AXI-lite and APB through the
// bridge; other addresses get a decode-error
// ------------------------------------------------
module soc_axil_wrap
   import soc_pkg::*;
(
   input  logic  clk_i,
   input  logic  arst_n_i,
   // Host manager
   input  addr_t host_aw_addr_i,
   input  logic  host_aw_valid_i,
   output logic  host_aw_ready_o,
   input  data_t host_w_data_i,
   input  strb_t host_w_strb_i,
   input  logic  host_w_valid_i,
   output logic  host_w_ready_o,
   output resp_t host_b_resp_o,
   output logic  host_b_valid_o,
   input  logic  host_b_ready_i,
   input  addr_t host_ar_addr_i,
   input  logic  host_ar_valid_i,
   output logic  host_ar_ready_o,
   output data_t host_r_data_o,
   output resp_t host_r_resp_o,
   output logic  host_r_valid_o,
   input  logic  host_r_ready_i,
   // DRAM
   output addr_t dram_aw_addr_o,
   output logic  dram_aw_valid_o,
   input  logic  dram_aw_ready_i,
   output data_t dram_w_data_o,
   output strb_t dram_w_strb_o,
   output logic  dram_w_valid_o,
   input  logic  dram_w_ready_i,
   input  resp_t dram_b_resp_i,
   input  logic  dram_b_valid_i,
   output logic  dram_b_ready_o,
   output addr_t dram_ar_addr_o,
   output logic  dram_ar_valid_o,
   input  logic  dram_ar_ready_i,
   input  data_t dram_r_data_i,
   input  resp_t dram_r_resp_i,
   input  logic  dram_r_valid_i,
   output logic  dram_r_ready_o,
   // APB
   output addr_t paddr_o,
   output logic  pwrite_o,
   output logic  psel_o,
   output logic  penable_o,
   output data_t pwdata_o,
   output strb_t pstrb_o,
   input  data_t prdata_i,
   input  logic  pready_i,
   input  logic  pslverr_i
);

   axil_if host_bus ();
   axil_if dram_bus ();
   axil_if apb_bus ();

   // ------------------------------------------------
   // Host side
   // ------------------------------------------------
   assign host_bus.aw_addr  = host_aw_addr_i;
   assign host_bus.aw_valid = host_aw_valid_i;
   assign host_aw_ready_o   = host_bus.aw_ready;
   assign host_bus.w_data   = host_w_data_i;
   assign host_bus.w_strb   = host_w_strb_i;
   assign host_bus.w_valid  = host_w_valid_i;
   assign host_w_ready_o    = host_bus.w_ready;
   assign host_b_resp_o     = host_bus.b_resp;
   assign host_b_valid_o    = host_bus.b_valid;
   assign host_bus.b_ready  = host_b_ready_i;
   assign host_bus.ar_addr  = host_ar_addr_i;
   assign host_bus.ar_valid = host_ar_valid_i;
   assign host_ar_ready_o   = host_bus.ar_ready;
   assign host_r_data_o     = host_bus.r_data;
   assign host_r_resp_o     = host_bus.r_resp;
   assign host_r_valid_o    = host_bus.r_valid;
   assign host_bus.r_ready  = host_r_ready_i;

   // ------------------------------------------------
   // DRAM side
   // ------------------------------------------------
   assign dram_aw_addr_o    = dram_bus.aw_addr;
   assign dram_aw_valid_o   = dram_bus.aw_valid;
   assign dram_bus.aw_ready = dram_aw_ready_i;
   assign dram_w_data_o     = dram_bus.w_data;
   assign dram_w_strb_o     = dram_bus.w_strb;
   assign dram_w_valid_o    = dram_bus.w_valid;
   assign dram_bus.w_ready  = dram_w_ready_i;
   assign dram_bus.b_resp   = dram_b_resp_i;
   assign dram_bus.b_valid  = dram_b_valid_i;
   assign dram_b_ready_o    = dram_bus.b_ready;
   assign dram_ar_addr_o    = dram_bus.ar_addr;
   assign dram_ar_valid_o   = dram_bus.ar_valid;
   assign dram_bus.ar_ready = dram_ar_ready_i;
   assign dram_bus.r_data   = dram_r_data_i;
   assign dram_bus.r_resp   = dram_r_resp_i;
   assign dram_bus.r_valid  = dram_r_valid_i;
   assign dram_r_ready_o    = dram_bus.r_ready;

   axil_addr_demux i_addr_demux (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .host     (host_bus),
      .dram     (dram_bus),
      .apb      (apb_bus)
   );

   axil_apb_bridge i_apb_bridge (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .axil      (apb_bus),
      .paddr_o   (paddr_o),
      .pwrite_o  (pwrite_o),
      .psel_o    (psel_o),
      .penable_o (penable_o),
      .pwdata_o  (pwdata_o),
      .pstrb_o   (pstrb_o),
      .prdata_i  (prdata_i),
      .pready_i  (pready_i),
      .pslverr_i (pslverr_i)
   );

endmodule

//--- dv/tb_soc_axil_wrap.sv
// ------------------------------------------------
// Transactions and expected results come from
// dv/stim_input.txt; run from the project root
// ------------------------------------------------
`include "soc_consts.svh"

module tb_soc_axil_wrap
   import soc_pkg::*;
();

   logic  clk_i = 1'b0;
   logic  arst_n_i;
   addr_t host_aw_addr_i, host_ar_addr_i, dram_aw_addr_o, dram_ar_addr_o, paddr_o;
   data_t host_w_data_i, host_r_data_o, dram_w_data_o, dram_r_data_i, pwdata_o, prdata_i;
   strb_t host_w_strb_i, dram_w_strb_o, pstrb_o;
   resp_t host_b_resp_o, host_r_resp_o, dram_b_resp_i, dram_r_resp_i;
   logic  host_aw_valid_i, host_aw_ready_o, host_w_valid_i, host_w_ready_o;
   logic  host_b_valid_o, host_b_ready_i, host_ar_valid_i, host_ar_ready_o;
   logic  host_r_valid_o, host_r_ready_i;
   logic  dram_aw_valid_o, dram_aw_ready_i, dram_w_valid_o, dram_w_ready_i;
   logic  dram_b_valid_i, dram_b_ready_o, dram_ar_valid_o, dram_ar_ready_i;
   logic  dram_r_valid_i, dram_r_ready_o;
   logic  pwrite_o, psel_o, penable_o, pready_i, pslverr_i;

   int    seed = 99;
   int    cycles = 0;
   int    limit;
   logic  quiet;
   logic  was_sel = 1'b0;
   logic  was_en = 1'b0;
   data_t dram_mem [addr_t];
   data_t apb_mem [addr_t];
   logic  op_q [$];
   addr_t addr_q [$];
   data_t wdata_q [$];
   resp_t resp_q [$];
   data_t rdata_q [$];

   soc_axil_wrap i_soc_axil_wrap (.*);

   always #4 clk_i = ~clk_i;

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "run stopped at the first error");
   endtask

   function automatic int rand_below(input int n);
      return {$random(seed)} % n;
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                    $time, what, got, exp));
   endtask

   // One host access and a random stall before the response is taken
   task automatic run_access(input logic is_read, input addr_t addr, input data_t wdata,
                             output resp_t resp, output data_t rdata);
      int hold;
      hold = rand_below(4);
      host_ar_addr_i  = addr;
      host_aw_addr_i  = addr;
      host_w_data_i   = wdata;
      host_ar_valid_i = is_read;
      host_aw_valid_i = !is_read;
      host_w_valid_i  = !is_read;
      @(negedge clk_i);
      while (!(is_read ? host_ar_ready_o : (host_aw_ready_o && host_w_ready_o)))
         @(negedge clk_i);
      @(posedge clk_i);
      #1;
      host_ar_valid_i = 1'b0;
      host_aw_valid_i = 1'b0;
      host_w_valid_i  = 1'b0;
      @(negedge clk_i);
      while (!(is_read ? host_r_valid_o : host_b_valid_o))
         @(negedge clk_i);
      resp  = is_read ? host_r_resp_o : host_b_resp_o;
      rdata = host_r_data_o;
      repeat (hold) begin
         @(negedge clk_i);
         assert ((is_read ? host_r_valid_o : host_b_valid_o) &&
                 (is_read ? host_r_resp_o : host_b_resp_o) === resp &&
                 (!is_read || host_r_data_o === rdata))
         else report_failure($sformatf("mismatch at %0t: response changed while stalled",
                                       $time));
      end
      @(posedge clk_i);
      #1;
      host_r_ready_i = is_read;
      host_b_ready_i = !is_read;
      @(posedge clk_i);
      #1;
      host_r_ready_i = 1'b0;
      host_b_ready_i = 1'b0;
   endtask

   // ------------------------------------------------
   // DRAM responder for writes and reads
   // ------------------------------------------------
   initial begin
      dram_aw_ready_i = 1'b0;
      dram_w_ready_i  = 1'b0;
      dram_b_valid_i  = 1'b0;
      dram_b_resp_i   = 2'b00;
      forever begin
         @(negedge clk_i);
         while (!(dram_aw_valid_o && dram_w_valid_o))
            @(negedge clk_i);
         check_value("DRAM write strobes", 32'(dram_w_strb_o), 32'(host_w_strb_i));
         dram_mem[dram_aw_addr_o] = dram_w_data_o;
         repeat (rand_below(4)) @(posedge clk_i);
         @(posedge clk_i);
         #1;
         dram_aw_ready_i = 1'b1;
         dram_w_ready_i  = 1'b1;
         @(posedge clk_i);
         #1;
         dram_aw_ready_i = 1'b0;
         dram_w_ready_i  = 1'b0;
         dram_b_valid_i  = 1'b1;
         @(negedge clk_i);
         while (!dram_b_ready_o)
            @(negedge clk_i);
         @(posedge clk_i);
         #1;
         dram_b_valid_i = 1'b0;
      end
   end

   initial begin
      addr_t a;
      dram_ar_ready_i = 1'b0;
      dram_r_valid_i  = 1'b0;
      dram_r_resp_i   = 2'b00;
      dram_r_data_i   = '0;
      forever begin
         @(negedge clk_i);
         while (!dram_ar_valid_o)
            @(negedge clk_i);
         a = dram_ar_addr_o;
         repeat (rand_below(4)) @(posedge clk_i);
         @(posedge clk_i);
         #1;
         dram_ar_ready_i = 1'b1;
         @(posedge clk_i);
         #1;
         dram_ar_ready_i = 1'b0;
         // Unwritten words read back as their address
         dram_r_data_i   = dram_mem.exists(a) ? dram_mem[a] : a;
         dram_r_valid_i  = 1'b1;
         @(negedge clk_i);
         while (!dram_r_ready_o)
            @(negedge clk_i);
         @(posedge clk_i);
         #1;
         dram_r_valid_i = 1'b0;
      end
   end

   // ------------------------------------------------
   // APB responder that errors on address bit 11
   // ------------------------------------------------
   initial begin
      addr_t a;
      pready_i  = 1'b0;
      pslverr_i = 1'b0;
      prdata_i  = '0;
      forever begin
         @(negedge clk_i);
         while (!(psel_o && !penable_o))
            @(negedge clk_i);
         a = paddr_o;
         if (pwrite_o)
            check_value("APB write strobes", 32'(pstrb_o), 32'(host_w_strb_i));
         @(posedge clk_i);
         #1;
         repeat (rand_below(3)) begin
            @(posedge clk_i);
            #1;
         end
         pready_i  = 1'b1;
         pslverr_i = a[11];
         prdata_i  = apb_mem.exists(a) ? apb_mem[a] : a;
         if (pwrite_o && !a[11])
            apb_mem[a] = pwdata_o;
         @(posedge clk_i);
         #1;
         pready_i  = 1'b0;
         pslverr_i = 1'b0;
      end
   end

   always @(negedge clk_i) begin
      if (arst_n_i) begin
         assert (!penable_o || (psel_o && was_sel))
         else report_failure("APB access phase seen without a setup cycle before it");
         assert (!(psel_o && was_sel && !was_en) || penable_o)
         else report_failure("APB setup phase lasted longer than one cycle");
         assert (!quiet || !(dram_aw_valid_o || dram_w_valid_o || dram_ar_valid_o || psel_o))
         else report_failure("unmapped access reached the DRAM or APB port");
      end
      was_sel = psel_o;
      was_en  = penable_o;
   end

   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (cycles > limit)
         report_failure($sformatf("timeout: no progress within %0d cycles", limit));
   end

   initial begin
      int    fd;
      int    n;
      string line;
      logic  op;
      addr_t a;
      data_t wd;
      data_t rd;
      data_t got_data;
      resp_t rsp;
      resp_t got_resp;
      arst_n_i        = 1'b0;
      quiet           = 1'b0;
      host_aw_addr_i  = '0;
      host_aw_valid_i = 1'b0;
      host_w_data_i   = '0;
      host_w_strb_i   = 4'hf;
      host_w_valid_i  = 1'b0;
      host_b_ready_i  = 1'b0;
      host_ar_addr_i  = '0;
      host_ar_valid_i = 1'b0;
      host_r_ready_i  = 1'b0;
      fd = $fopen("dv/stim_input.txt", "r");
      if (fd == 0)
         report_failure("could not open dv/stim_input.txt");
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // Comment and blank lines do not scan
         if (n > 0 && $sscanf(line, "%h %h %h %h %h", op, a, wd, rsp, rd) == 5) begin
            op_q.push_back(op);
            addr_q.push_back(a);
            wdata_q.push_back(wd);
            resp_q.push_back(rsp);
            rdata_q.push_back(rd);
         end
      end
      $fclose(fd);
      limit = 40 * op_q.size() + 100;
      if (op_q.size() == 0)
         report_failure("data file holds no transactions");
      repeat (8) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      for (int i = 0; i < op_q.size(); i++) begin
         @(posedge clk_i);
         #1;
         quiet = (resp_q[i] == `SOC_RESP_DECERR);
         run_access(op_q[i], addr_q[i], wdata_q[i], got_resp, got_data);
         check_value($sformatf("response of line %0d", i), 32'(got_resp), 32'(resp_q[i]));
         if (op_q[i])
            check_value($sformatf("read data of line %0d", i), got_data, rdata_q[i]);
         quiet = 1'b0;
      end
      $display("Testbench passed");
      $finish;
   end

endmodule

//--- dv/stim_input.txt
// op addr wdata resp rdata, all hex; op 0 is a write, 1 a read
// resp 0 OKAY, 2 SLVERR, 3 DECERR; rdata is checked on reads only
0 80000000 11112222 0 00000000
1 80000000 00000000 0 11112222
1 80000100 00000000 0 80000100
0 9ffffffc a5a5a5a5 0 00000000
1 9ffffffc 00000000 0 a5a5a5a5
0 a0000000 12345678 3 00000000
1 a0000000 00000000 3 00000000
1 7ffffffc 00000000 3 00000000
0 60000000 cafef00d 0 00000000
1 60000000 00000000 0 cafef00d
1 60000020 00000000 0 60000020
0 60000800 0badbeef 2 00000000
1 60000800 00000000 2 60000800
0 6ffffffc 5a5a5a5a 2 00000000
1 6ffffffc 00000000 2 6ffffffc
0 5ffffffc 87654321 3 00000000
1 5ffffffc 00000000 3 00000000
1 70000000 00000000 3 00000000
0 00010000 deadbeef 3 00000000
1 00010000 00000000 3 00000000
0 80000000 33334444 0 00000000
1 80000000 00000000 0 33334444

//--- src.f
+incdir+logic
logic/soc_pkg.sv
logic/axil_if.sv
logic/axil_addr_demux.sv
logic/axil_apb_bridge.sv
logic/soc_axil_wrap.sv
dv/tb_soc_axil_wrap.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run with Verilator; the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_soc_axil_wrap -f src.f > sim.log 2>&1 &&
   ./obj_dir/Vtb_soc_axil_wrap >> sim.log 2>&1 ||
   echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
